//--- Bender.yml
package:
  name: cpu16

sources:
  - hw/cpuPkg.sv
  - hw/cpuCtrlIf.sv
  - hw/alu.sv
  - hw/regBlock.sv
  - hw/datapath.sv
  - hw/controller.sv
  - hw/cpuTop.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tbCpu.sv

//--- hw/alu.sv
module alu import cpuPkg::*; (
  input  logic [DataWidth-1:0] Op1,
  input  logic [DataWidth-1:0] Op2,
  input  aluOpT                OpCode,
  output logic [DataWidth-1:0] Result,
  output logic                 Zflag
);

  always_comb begin
    case (OpCode)
      Add:     Result = Op1 + Op2;
      Sub:     Result = Op1 - Op2;
      And:     Result = Op1 & Op2;
      Or:      Result = Op1 | Op2;
      Xor:     Result = Op1 ^ Op2;
      Shl:     Result = Op1 << Op2[3:0];  // Up to 15 places
      PassB:   Result = Op2;
      PassA:   Result = Op1;
      default: Result = '0;
    endcase
  end

  assign Zflag = (Result == '0);

endmodule

//--- hw/controller.sv
module controller import cpuPkg::*; (
  input  logic         Clock,
  input  logic         nReset,
  cpuCtrlIf.controller Ctrl,
  output logic         MemRead,
  output logic         MemWrite,
  output logic         Halted
);

  localparam logic [3:0] SReset     = 4'd0;
  localparam logic [3:0] SFetchAddr = 4'd1;
  localparam logic [3:0] SFetchRead = 4'd2;
  localparam logic [3:0] SDecode    = 4'd3;
  localparam logic [3:0] SExecute   = 4'd4;
  localparam logic [3:0] SWriteBack = 4'd5;
  localparam logic [3:0] SMemAddr   = 4'd6;
  localparam logic [3:0] SLoad      = 4'd7;
  localparam logic [3:0] SStore     = 4'd8;
  localparam logic [3:0] SBranch    = 4'd9;
  localparam logic [3:0] SRet       = 4'd10;
  localparam logic [3:0] SHalt      = 4'd11;

  logic [3:0] State;
  logic [3:0] NextState;
  opcodeT     Opcode;
  aluOpT      RegAluOp;

  assign Opcode = Ctrl.IrControl.opcode;

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      State <= SReset;
    end else begin
      State <= NextState;
    end
  end

  always_comb begin
    NextState = State;
    case (State)
      SReset:     NextState = SFetchAddr;
      SFetchAddr: NextState = SFetchRead;
      SFetchRead: NextState = SDecode;
      SDecode: begin
        case (Opcode)
          OpRet:   NextState = SRet;
          OpHalt:  NextState = SHalt;
          default: NextState = SExecute;
        endcase
      end
      SExecute: begin
        case (Opcode)
          OpAdd, OpSub, OpAnd, OpOr, OpXor, OpShl, OpLdi: NextState = SWriteBack;
          OpLd, OpSt:          NextState = SMemAddr;
          OpBz, OpJmp, OpCall: NextState = SBranch;
          default:             NextState = SFetchAddr;  // Unused opcodes act as NOP
        endcase
      end
      SMemAddr:   NextState = (Opcode == OpLd) ? SLoad : SStore;
      SWriteBack: NextState = SFetchAddr;
      SLoad:      NextState = SFetchAddr;
      SStore:     NextState = SFetchAddr;
      SBranch:    NextState = SFetchAddr;
      SRet:       NextState = SFetchAddr;
      SHalt:      NextState = SHalt;  // Left only by reset
      default:    NextState = SReset;
    endcase
  end

  // ALU operation of the register format instructions
  always_comb begin
    case (Opcode)
      OpSub:   RegAluOp = Sub;
      OpAnd:   RegAluOp = And;
      OpOr:    RegAluOp = Or;
      OpXor:   RegAluOp = Xor;
      OpShl:   RegAluOp = Shl;
      default: RegAluOp = Add;
    endcase
  end

  always_comb begin
    Ctrl.AluOp     = Add;
    Ctrl.Op1Sel    = 1'b0;
    Ctrl.Op2Sel    = 1'b0;
    Ctrl.ImmSigned = 1'b0;
    Ctrl.AluEn     = 1'b0;
    Ctrl.PcEn      = 1'b0;
    Ctrl.LrEn      = 1'b0;
    Ctrl.MemEn     = 1'b0;
    Ctrl.PcWe      = 1'b0;
    Ctrl.PcSel     = PcSrcInc;
    Ctrl.IrWe      = 1'b0;
    Ctrl.LrWe      = 1'b0;
    Ctrl.MarWe     = 1'b0;
    Ctrl.RegWe     = 1'b0;
    Ctrl.WdSel     = 1'b0;
    Ctrl.FlagWe    = 1'b0;
    MemRead        = 1'b0;
    MemWrite       = 1'b0;
    case (State)
      SFetchAddr: begin
        Ctrl.PcEn  = 1'b1;  // PC to address register
        Ctrl.MarWe = 1'b1;
      end
      SFetchRead: begin
        MemRead    = 1'b1;
        Ctrl.MemEn = 1'b1;
        Ctrl.IrWe  = 1'b1;
        Ctrl.PcWe  = 1'b1;  // PC moves to the next word
      end
      SExecute: begin
        case (Opcode)
          OpAdd, OpSub, OpAnd, OpOr, OpXor, OpShl: begin
            Ctrl.AluOp  = RegAluOp;
            Ctrl.Op2Sel = 1'b1;
            Ctrl.FlagWe = 1'b1;
          end
          OpLdi: begin
            Ctrl.AluOp     = PassB;
            Ctrl.ImmSigned = 1'b1;
          end
          OpLd: begin
            Ctrl.AluOp = PassB;  // Absolute word address
          end
          OpSt: begin
            Ctrl.AluOp = PassA;  // Address from rs1
          end
          OpBz, OpJmp, OpCall: begin
            Ctrl.AluOp     = Add;  // PC relative target
            Ctrl.Op1Sel    = 1'b1;
            Ctrl.ImmSigned = 1'b1;
            if (Opcode == OpCall) begin
              Ctrl.PcEn = 1'b1;  // Return address into LR
              Ctrl.LrWe = 1'b1;
            end
          end
          default: ;
        endcase
      end
      SWriteBack: begin
        Ctrl.RegWe = 1'b1;
      end
      SMemAddr: begin
        Ctrl.AluEn = 1'b1;
        Ctrl.MarWe = 1'b1;
      end
      SLoad: begin
        MemRead    = 1'b1;
        Ctrl.MemEn = 1'b1;
        Ctrl.RegWe = 1'b1;
        Ctrl.WdSel = 1'b1;
      end
      SStore: begin
        MemWrite = 1'b1;
      end
      SBranch: begin
        Ctrl.PcSel = PcSrcAlu;
        Ctrl.PcWe  = (Opcode != OpBz) || Ctrl.Z;
      end
      SRet: begin
        Ctrl.LrEn  = 1'b1;
        Ctrl.PcSel = PcSrcLr;
        Ctrl.PcWe  = 1'b1;
      end
      default: ;
    endcase
  end

  assign Halted = (State == SHalt);

  memExclusive: assert property (@(posedge Clock) disable iff (!nReset)
    !(MemRead && MemWrite))
    else $error("MemRead and MemWrite high together");

  // Instruction load only in the read cycle right after the fetch address cycle
  irLoadInFetch: assert property (@(posedge Clock) disable iff (!nReset)
    Ctrl.IrWe |-> (State == SFetchRead) && ($past(State) == SFetchAddr))
    else $error("IR written outside instruction fetch");

endmodule

//--- hw/cpuCtrlIf.sv
interface cpuCtrlIf import cpuPkg::*; ();

  aluOpT      AluOp;
  logic       Op1Sel;     // Low picks Rd1 and high picks PC
  logic       Op2Sel;     // Low picks extended imm8 and high picks Rd2
  logic       ImmSigned;  // Sign extend imm8
  logic       AluEn;      // Bus driver enables
  logic       PcEn;
  logic       LrEn;
  logic       MemEn;
  logic       PcWe;
  logic [1:0] PcSel;      // One of the PcSrc codes
  logic       IrWe;
  logic       LrWe;
  logic       MarWe;
  logic       RegWe;
  logic       WdSel;      // Register write data from bus when high
  logic       FlagWe;
  irControlT  IrControl;  // Decoded opcode and rd
  logic       Z;          // Registered zero flag

  modport controller (
    output AluOp, Op1Sel, Op2Sel, ImmSigned,
    output AluEn, PcEn, LrEn, MemEn,
    output PcWe, PcSel, IrWe, LrWe, MarWe, RegWe, WdSel, FlagWe,
    input  IrControl, Z
  );

  modport datapath (
    input  AluOp, Op1Sel, Op2Sel, ImmSigned,
    input  AluEn, PcEn, LrEn, MemEn,
    input  PcWe, PcSel, IrWe, LrWe, MarWe, RegWe, WdSel, FlagWe,
    output IrControl, Z
  );

endinterface

//--- hw/cpuPkg.sv
package cpuPkg;

  localparam int DataWidth    = 16;  // Word, register, bus and address width
  localparam int RegAddrWidth = 3;   // Eight registers

  // Opcodes live in instruction bits 15:11
  // Only the six register ALU operations update the Z flag
  // Branch targets are relative to the address after the branch
  typedef enum logic [4:0] {
    OpAdd  = 5'd0,   // rd = rs1 + rs2
    OpSub  = 5'd1,   // rd = rs1 - rs2
    OpAnd  = 5'd2,   // rd = rs1 & rs2
    OpOr   = 5'd3,   // rd = rs1 | rs2
    OpXor  = 5'd4,   // rd = rs1 ^ rs2
    OpShl  = 5'd5,   // rd = rs1 << rs2[3:0]
    OpLdi  = 5'd6,   // rd = sext(imm8)
    OpLd   = 5'd7,   // rd = mem[zext(imm8)]
    OpSt   = 5'd8,   // mem[rs1] = rs2
    OpBz   = 5'd9,   // Taken only when Z is set
    OpJmp  = 5'd10,  // pc = pc + 1 + sext(imm8)
    OpCall = 5'd11,  // lr = pc + 1 then jump as JMP
    OpRet  = 5'd12,  // pc = lr
    OpHalt = 5'd13
  } opcodeT;

  typedef enum logic [2:0] {
    Add   = 3'd0,
    Sub   = 3'd1,
    And   = 3'd2,
    Or    = 3'd3,
    Xor   = 3'd4,
    Shl   = 3'd5,  // Shift amount from Op2[3:0]
    PassB = 3'd6,
    PassA = 3'd7   // Register base for ST addresses
  } aluOpT;

  // Program counter source select
  localparam logic [1:0] PcSrcLr  = 2'd0;
  localparam logic [1:0] PcSrcAlu = 2'd1;
  localparam logic [1:0] PcSrcBus = 2'd2;
  localparam logic [1:0] PcSrcInc = 2'd3;

  // Register format for ALU ops and ST, immediate format for the rest
  typedef union packed {
    struct packed {
      opcodeT                  opcode;
      logic [1:0]              spare;
      logic [RegAddrWidth-1:0] rs2;
      logic [RegAddrWidth-1:0] rs1;
      logic [RegAddrWidth-1:0] rd;
    } rType;
    struct packed {
      opcodeT                  opcode;
      logic [7:0]              imm8;
      logic [RegAddrWidth-1:0] rd;
    } iType;
  } instrT;

  typedef struct packed {
    opcodeT                  opcode;
    logic [RegAddrWidth-1:0] rd;
  } irControlT;

endpackage

//--- hw/cpuTop.sv
module cpuTop #(
  parameter int DataWidth = 16
) (
  input  logic                 Clock,
  input  logic                 nReset,
  output logic [DataWidth-1:0] MemAddr,
  input  logic [DataWidth-1:0] MemRData,
  output logic [DataWidth-1:0] MemWData,
  output logic                 MemRead,
  output logic                 MemWrite,
  output logic                 Halted
);

  cpuCtrlIf i_ctrlIf ();  // Strobes and decoded fields

  controller i_controller (
    .Clock    (Clock),
    .nReset   (nReset),
    .Ctrl     (i_ctrlIf.controller),
    .MemRead  (MemRead),
    .MemWrite (MemWrite),
    .Halted   (Halted)
  );

  datapath #(
    .DataWidth (DataWidth)
  ) i_datapath (
    .Clock    (Clock),
    .nReset   (nReset),
    .Ctrl     (i_ctrlIf.datapath),
    .MemRData (MemRData),
    .MemAddr  (MemAddr),
    .MemWData (MemWData)
  );

endmodule

//--- hw/datapath.sv
module datapath import cpuPkg::*; #(
  parameter int DataWidth = 16
) (
  input  logic                 Clock,
  input  logic                 nReset,
  cpuCtrlIf.datapath           Ctrl,
  input  logic [DataWidth-1:0] MemRData,
  output logic [DataWidth-1:0] MemAddr,
  output logic [DataWidth-1:0] MemWData
);

  localparam int NumBusDrivers = 4;

  tri   [DataWidth-1:0]     SysBus;
  logic [DataWidth-1:0]     BusSrc [NumBusDrivers];
  logic [NumBusDrivers-1:0] BusEn;
  logic [DataWidth-1:0]     Pc;
  logic [DataWidth-1:0]     Lr;
  logic [DataWidth-1:0]     Mar;
  logic [DataWidth-1:0]     AluOut;
  instrT                    Ir;
  logic                     ZReg;
  logic [DataWidth-1:0]     Rd1;
  logic [DataWidth-1:0]     Rd2;
  logic [DataWidth-1:0]     WData;
  logic [DataWidth-1:0]     Op1;
  logic [DataWidth-1:0]     Op2;
  logic [DataWidth-1:0]     ExtImm;
  logic [DataWidth-1:0]     AluRes;
  logic                     AluZero;

  regBlock i_regBlock (
    .Clock (Clock),
    .Rs1   (Ir.rType.rs1),
    .Rs2   (Ir.rType.rs2),
    .Rw    (Ir.rType.rd),
    .We    (Ctrl.RegWe),
    .WData (WData),
    .Rd1   (Rd1),
    .Rd2   (Rd2)
  );

  alu i_alu (
    .Op1    (Op1),
    .Op2    (Op2),
    .OpCode (Ctrl.AluOp),
    .Result (AluRes),
    .Zflag  (AluZero)
  );

  // Four tri-state drivers share the system bus
  assign BusSrc = '{Pc, AluOut, Lr, MemRData};
  assign BusEn  = {Ctrl.MemEn, Ctrl.LrEn, Ctrl.AluEn, Ctrl.PcEn};

  for (genvar i = 0; i < NumBusDrivers; i++) begin : g_busDrv
    assign SysBus = BusEn[i] ? BusSrc[i] : 'z;
  end

  // Sign or zero extension of imm8
  assign ExtImm = {{(DataWidth-8){Ctrl.ImmSigned & Ir.iType.imm8[7]}}, Ir.iType.imm8};

  assign Op1   = Ctrl.Op1Sel ? Pc : Rd1;
  assign Op2   = Ctrl.Op2Sel ? Rd2 : ExtImm;
  assign WData = Ctrl.WdSel ? SysBus : AluOut;  // Load data or ALU result

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      AluOut <= '0;
      ZReg   <= 1'b0;
    end else begin
      AluOut <= AluRes;  // Free running
      if (Ctrl.FlagWe) begin
        ZReg <= AluZero;
      end
    end
  end

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      Pc <= '0;
    end else if (Ctrl.PcWe) begin
      case (Ctrl.PcSel)
        PcSrcLr:  Pc <= Lr;
        PcSrcAlu: Pc <= AluOut;
        PcSrcBus: Pc <= SysBus;
        default:  Pc <= Pc + 1'b1;
      endcase
    end
  end

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      Ir  <= '0;
      Lr  <= '0;
      Mar <= '0;
    end else begin
      if (Ctrl.IrWe) begin
        Ir <= SysBus;
      end
      if (Ctrl.LrWe) begin
        Lr <= SysBus;  // PC is on the bus during CALL
      end
      if (Ctrl.MarWe) begin
        Mar <= SysBus;
      end
    end
  end

  assign MemAddr  = Mar;
  assign MemWData = Rd2;  // Store data from rs2

  assign Ctrl.IrControl = '{opcode: Ir.rType.opcode, rd: Ir.rType.rd};
  assign Ctrl.Z         = ZReg;

  busOneDriver: assert property (@(posedge Clock) disable iff (!nReset)
    $onehot0(BusEn))
    else $error("More than one system bus driver enabled");

  // Registers loaded from the bus need a driver in that cycle
  busDrivenOnLoad: assert property (@(posedge Clock) disable iff (!nReset)
    (Ctrl.IrWe || Ctrl.LrWe || Ctrl.MarWe) |-> |BusEn)
    else $error("Register loaded from a floating bus");

endmodule

//--- hw/regBlock.sv
module regBlock import cpuPkg::*; (
  input  logic                    Clock,
  input  logic [RegAddrWidth-1:0] Rs1,
  input  logic [RegAddrWidth-1:0] Rs2,
  input  logic [RegAddrWidth-1:0] Rw,
  input  logic                    We,
  input  logic [DataWidth-1:0]    WData,
  output logic [DataWidth-1:0]    Rd1,
  output logic [DataWidth-1:0]    Rd2
);

  localparam int NumRegs = 2 ** RegAddrWidth;

  logic [DataWidth-1:0] Regs [NumRegs];

  always_ff @(posedge Clock) begin
    if (We) begin
      Regs[Rw] <= WData;  // R0 is writable like the others
    end
  end

  // Asynchronous read ports
  assign Rd1 = Regs[Rs1];
  assign Rd2 = Regs[Rs2];

endmodule

//--- sim/cpuRefModel.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Instruction-set model of the core
// Returns the number of stores and fills in their addresses and data in order
function automatic int runModel(
  input  logic [DataWidth-1:0] prog [MemWords],
  output logic [DataWidth-1:0] finalMem [MemWords],
  output logic [DataWidth-1:0] stAddr [MaxStores],
  output logic [DataWidth-1:0] stData [MaxStores],
  output int                   haltAddr
);
  logic [DataWidth-1:0] regs [8];
  logic [DataWidth-1:0] pc;
  logic [DataWidth-1:0] lr;
  logic [DataWidth-1:0] a;
  logic [DataWidth-1:0] b;
  logic [DataWidth-1:0] res;
  logic [DataWidth-1:0] simm;
  logic                 z;
  instrT                ir;
  int                   count;

  finalMem = prog;
  for (int r = 0; r < 8; r++) begin
    regs[r] = '0;
  end
  pc       = '0;
  lr       = '0;
  z        = 1'b0;
  count    = 0;
  haltAddr = -1;
  for (int step = 0; step < MaxSteps && haltAddr < 0; step++) begin
    ir   = finalMem[pc[7:0]];  // Word addressed memory of 256 words
    a    = regs[ir.rType.rs1];
    b    = regs[ir.rType.rs2];
    simm = {{(DataWidth-8){ir.iType.imm8[7]}}, ir.iType.imm8};
    pc   = pc + 1'b1;
    case (ir.rType.opcode)
      OpAdd, OpSub, OpAnd, OpOr, OpXor, OpShl: begin
        case (ir.rType.opcode)
          OpAdd:   res = a + b;
          OpSub:   res = a - b;
          OpAnd:   res = a & b;
          OpOr:    res = a | b;
          OpXor:   res = a ^ b;
          default: res = a << b[3:0];
        endcase
        regs[ir.rType.rd] = res;
        z = (res == '0);  // Only these six touch Z
      end
      OpLdi: regs[ir.iType.rd] = simm;
      OpLd:  regs[ir.iType.rd] = finalMem[ir.iType.imm8];  // Zero extended address
      OpSt: begin
        finalMem[a[7:0]] = b;
        if (count < MaxStores) begin
          stAddr[count] = a;
          stData[count] = b;
        end
        count++;
      end
      OpBz: begin
        if (z) begin
          pc = pc + simm;
        end
      end
      OpJmp: pc = pc + simm;
      OpCall: begin
        lr = pc;  // Address after the call
        pc = pc + simm;
      end
      OpRet:  pc = lr;
      OpHalt: haltAddr = int'(pc - 1'b1);
      default: ;  // Unused opcodes do nothing
    endcase
  end
  return count;
endfunction

`endif

//--- sim/tbCpu.sv
module tbCpu import cpuPkg::*; ();

  localparam int MemWords      = 256;
  localparam int MaxStores     = 64;
  localparam int MaxSteps      = 2000;  // Model step limit
  localparam int TimeoutCycles = 4000;
  localparam int ResetCycles   = 10;
  localparam int Seed          = 32'hbb4;

  `include "cpuRefModel.svh"

  logic                 Clock;
  logic                 nReset;
  logic [DataWidth-1:0] MemAddr;
  logic [DataWidth-1:0] MemRData;
  logic [DataWidth-1:0] MemWData;
  logic                 MemRead;
  logic                 MemWrite;
  logic                 Halted;

  logic [DataWidth-1:0] mem [MemWords];
  logic [DataWidth-1:0] image [MemWords];
  logic [DataWidth-1:0] expMem [MemWords];
  logic [DataWidth-1:0] expAddr [MaxStores];
  logic [DataWidth-1:0] expData [MaxStores];
  int                   expCount;
  int                   expHalt;
  int                   storeIdx;
  int                   pos;
  bit                   sawRead;
  string                testName;

  cpuTop #(
    .DataWidth (DataWidth)
  ) i_cpuTop (
    .Clock    (Clock),
    .nReset   (nReset),
    .MemAddr  (MemAddr),
    .MemRData (MemRData),
    .MemWData (MemWData),
    .MemRead  (MemRead),
    .MemWrite (MemWrite),
    .Halted   (Halted)
  );

  initial begin
    Clock = 1'b0;
    forever #50 Clock = ~Clock;
  end

  // Memory model with read data valid while MemRead is high
  assign MemRData = MemRead ? mem[MemAddr[7:0]] : '0;

  always @(posedge Clock) begin
    if (nReset && MemWrite) begin
      mem[MemAddr[7:0]] <= MemWData;
    end
  end

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Compares every store in order against the model
  always @(negedge Clock) begin
    if (nReset && MemRead && !sawRead) begin
      assert (MemAddr == '0)
        else failNow($sformatf("MISMATCH %s: first read address expected %h actual %h",
                               testName, 16'h0000, MemAddr));
      sawRead = 1'b1;
    end
    if (nReset && MemRead) begin
      assert (MemAddr < MemWords)
        else failNow($sformatf("Read from %h beyond the %0d word memory in test %s",
                               MemAddr, MemWords, testName));
    end
    if (nReset && Halted) begin
      assert (!MemRead) else failNow($sformatf("Memory read after HALT in test %s", testName));
    end
    if (nReset && MemWrite) begin
      assert (storeIdx < expCount)
        else failNow($sformatf("Unexpected extra store to %h in test %s", MemAddr, testName));
      assert (MemAddr == expAddr[storeIdx])
        else failNow($sformatf("MISMATCH %s: store %0d address expected %h actual %h",
                               testName, storeIdx, expAddr[storeIdx], MemAddr));
      assert (MemWData == expData[storeIdx])
        else failNow($sformatf("MISMATCH %s: store %0d data expected %h actual %h",
                               testName, storeIdx, expData[storeIdx], MemWData));
      storeIdx++;
    end
  end

  function automatic logic [DataWidth-1:0] rInstr(opcodeT op, int rd, int rs1, int rs2);
    return {op, 2'b00, 3'(rs2), 3'(rs1), 3'(rd)};
  endfunction

  function automatic logic [DataWidth-1:0] iInstr(opcodeT op, int rd, int imm);
    return {op, 8'(imm), 3'(rd)};
  endfunction

  task automatic put(input logic [DataWidth-1:0] word);
    image[pos] = word;
    pos++;
  endtask

  task automatic branchTo(input opcodeT op, input int target);
    put(iInstr(op, 0, target - (pos + 1)));  // Relative to the next word
  endtask

  task automatic clearImage();
    for (int a = 0; a < MemWords; a++) begin
      image[a] = 16'hf000 | 16'(a);  // Unused opcode plus address
    end
    pos = 0;
  endtask

  task automatic runTest(input string name);
    int cycles;
    testName = name;
    @(posedge Clock);
    nReset <= 1'b0;
    for (int i = 0; i < MemWords; i++) begin
      mem[i] <= image[i];
    end
    expCount = runModel(image, expMem, expAddr, expData, expHalt);
    storeIdx = 0;
    sawRead  = 1'b0;
    assert (expHalt >= 0 && expCount <= MaxStores)
      else failNow($sformatf("Reference model of test %s did not reach HALT", name));
    for (int i = 0; i < ResetCycles; i++) begin
      @(negedge Clock);
      assert (!MemRead && !MemWrite && !Halted)
        else failNow($sformatf("Strobe or Halted high during reset in test %s", name));
      @(posedge Clock);
    end
    nReset <= 1'b1;
    @(negedge Clock);
    assert (!MemRead && !MemWrite && !Halted)
      else failNow($sformatf("Strobe or Halted high right after reset in test %s", name));
    cycles = 0;
    while (!Halted && cycles < TimeoutCycles) begin
      @(negedge Clock);
      cycles++;
    end
    assert (Halted) else failNow($sformatf("Timeout waiting for Halted in test %s", name));
    for (int i = 0; i < 8; i++) begin  // Core must stay halted
      @(negedge Clock);
      assert (Halted) else failNow($sformatf("Halted dropped in test %s", name));
    end
    assert (storeIdx == expCount)
      else failNow($sformatf("MISMATCH %s: store count expected %0d actual %0d",
                             name, expCount, storeIdx));
    assert (MemAddr == 16'(expHalt))
      else failNow($sformatf("MISMATCH %s: halt address expected %h actual %h",
                             name, 16'(expHalt), MemAddr));
    for (int a = 0; a < MemWords; a++) begin
      assert (mem[a] === expMem[a])
        else failNow($sformatf("MISMATCH %s: mem[%0h] expected %h actual %h",
                               name, a, expMem[a], mem[a]));
    end
  endtask

  task automatic aluOps();
    opcodeT ops [6];
    int     src1;
    int     src3;
    ops  = '{OpAdd, OpSub, OpAnd, OpOr, OpXor, OpShl};
    clearImage();
    src1 = 128 + $urandom % 128;
    src3 = 128 + $urandom % 128;
    image[src1] = 16'($urandom);
    image[src3] = 16'($urandom);
    put(iInstr(OpLd, 1, src1));
    put(iInstr(OpLd, 3, src3));
    put(iInstr(OpLdi, 2, $urandom));
    put(iInstr(OpLdi, 4, $urandom));
    for (int k = 0; k < 12; k++) begin
      put(rInstr(ops[k % 6], 5, (k < 6) ? 1 : 3, 1 + $urandom % 4));
      put(iInstr(OpLdi, 7, 8'h40 + k));
      put(rInstr(OpSt, 0, 7, 5));
    end
    put(iInstr(OpHalt, 0, 0));
    runTest("alu");
  endtask

  task automatic immExtension();
    logic [7:0] imms [6];
    imms = '{8'h80, 8'h7f, 8'hff, 8'h00, 8'($urandom) | 8'h80, 8'($urandom) & 8'h7f};
    clearImage();
    for (int k = 0; k < 6; k++) begin
      put(iInstr(OpLdi, 1, imms[k]));
      put(iInstr(OpLdi, 7, 8'h40 + k));
      put(rInstr(OpSt, 0, 7, 1));
    end
    put(iInstr(OpHalt, 0, 0));
    runTest("ldi");
  endtask

  task automatic loadStore();
    int src;
    int dst;
    clearImage();
    for (int k = 0; k < 8; k++) begin
      src = 128 + $urandom % 128;  // Data area above the stores
      dst = 64 + $urandom % 64;
      image[src] = 16'($urandom);
      put(iInstr(OpLd, 1 + k % 6, src));
      put(iInstr(OpLdi, 7, dst));
      put(rInstr(OpSt, 0, 7, 1 + k % 6));
    end
    put(iInstr(OpHalt, 0, 0));
    runTest("memory");
  endtask

  task automatic branches();
    int v;
    int n;
    int loopTop;
    clearImage();
    v = 1 + $urandom % 127;
    n = 2 + $urandom % 4;
    put(iInstr(OpLdi, 1, v));
    put(iInstr(OpLdi, 2, v));
    put(iInstr(OpLdi, 4, 8'h11));  // Marker of the path meant to run
    put(iInstr(OpLdi, 5, 8'h22));  // Marker of the skipped path
    put(iInstr(OpLdi, 6, 1));
    put(iInstr(OpLdi, 7, 8'h40));
    put(rInstr(OpSub, 3, 1, 2));   // Zero so BZ is taken
    branchTo(OpBz, pos + 2);
    put(rInstr(OpSt, 0, 7, 5));
    put(rInstr(OpSt, 0, 7, 4));
    put(iInstr(OpLdi, 7, 8'h41));
    put(rInstr(OpOr, 3, 1, 6));    // Nonzero so BZ falls through
    branchTo(OpBz, pos + 2);
    put(rInstr(OpSt, 0, 7, 5));
    put(rInstr(OpSt, 0, 7, 4));
    put(iInstr(OpLdi, 7, 8'h42));
    branchTo(OpJmp, pos + 2);
    put(rInstr(OpSt, 0, 7, 5));
    put(rInstr(OpSt, 0, 7, 4));
    put(iInstr(OpLdi, 1, n));      // Count down loop with a backward JMP
    put(iInstr(OpLdi, 7, 8'h48));
    loopTop = pos;
    put(rInstr(OpSt, 0, 7, 1));
    put(rInstr(OpAdd, 7, 7, 6));
    put(rInstr(OpSub, 1, 1, 6));
    branchTo(OpBz, pos + 2);
    branchTo(OpJmp, loopTop);
    put(iInstr(OpHalt, 0, 0));
    runTest("branch");
  endtask

  task automatic callReturn();
    int subAddr;
    clearImage();
    subAddr = 8'h20;
    pos     = subAddr;
    put(rInstr(OpSt, 0, 7, 4));    // Marker from inside the subroutine
    put(rInstr(OpAdd, 7, 7, 6));
    put(rInstr(OpAdd, 4, 4, 6));
    put(rInstr(OpAdd, 5, 4, 4));
    put(iInstr(OpRet, 0, 0));
    pos = 0;
    put(iInstr(OpLdi, 7, 8'h40));
    put(iInstr(OpLdi, 4, $urandom));
    put(iInstr(OpLdi, 6, 1));
    branchTo(OpCall, subAddr);
    put(rInstr(OpSt, 0, 7, 5));    // Reached only through RET
    put(rInstr(OpAdd, 7, 7, 6));
    branchTo(OpCall, subAddr);
    put(rInstr(OpSt, 0, 7, 5));
    put(iInstr(OpHalt, 0, 0));
    runTest("call");
  endtask

  initial begin
    nReset = 1'b0;
    void'($urandom(Seed));
    aluOps();
    immExtension();
    loadStore();
    branches();
    callReturn();
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+sim
hw/cpuPkg.sv
hw/cpuCtrlIf.sv
hw/alu.sv
hw/regBlock.sv
hw/datapath.sv
hw/controller.sv
hw/cpuTop.sv
sim/tbCpu.sv
